// ==== src/ldr_pkg.sv ====
package ldr_pkg;

	// wishbone data path, one 32-bit word per cycle
	localparam int DATA_W = 32;

	// one select per byte lane
	localparam int SEL_W = DATA_W / 8;

	// byte address as seen by the loader and the core
	localparam int ADDR_W = 24;

	// ram word address, bits 11..2 of the byte address
	localparam int MEM_AW = 10;

	// first downloaded word lands here, word aligned
	localparam logic [ADDR_W-1:0] LOAD_BASE = 24'h000400;

	// flops per spi input synchroniser
	localparam int SYNC_STAGES = 2;

endpackage

// ==== src/wb_if.sv ====
`timescale 1ns/10ps

interface wb_if;

	// cycle framing
	logic cyc;
	logic stb;
	logic we;

	// request payload
	logic [ldr_pkg::SEL_W-1:0]  sel;
	logic [ldr_pkg::ADDR_W-1:0] adr;
	logic [ldr_pkg::DATA_W-1:0] dat_w;

	// response
	logic [ldr_pkg::DATA_W-1:0] dat_r;
	logic                       ack;

	// bus owner side
	modport master (
		output cyc, stb, we, sel, adr, dat_w,
		input  dat_r, ack
	);

	// memory side
	modport slave (
		input  cyc, stb, we, sel, adr, dat_w,
		output dat_r, ack
	);

endinterface

// ==== src/loader_if.sv ====
`timescale 1ns/10ps

interface loader_if;

	// single cycle write request
	logic                       wr;
	// held until the next wr pulse
	logic [ldr_pkg::ADDR_W-1:0] addr;
	logic [ldr_pkg::SEL_W-1:0]  sel;
	logic [ldr_pkg::DATA_W-1:0] data;

	// packer side
	modport source (output wr, addr, sel, data);

	// bus mux side
	modport sink (input wr, addr, sel, data);

endinterface

// ==== src/spi_byte_rx.sv ====
`timescale 1ns/10ps

module spi_byte_rx (
	input  logic       clk_32m,
	input  logic       rst_n_i,
	input  logic       spi_sck_i,
	input  logic       spi_ss_n_i,
	input  logic       spi_di_i,
	output logic [7:0] byte_o,
	output logic       byte_valid_o,
	output logic       active_o
);

	// synchroniser chains, oldest sample in the top bit
	logic [ldr_pkg::SYNC_STAGES-1:0] sck_sync;
	logic [ldr_pkg::SYNC_STAGES-1:0] ss_sync;
	logic [ldr_pkg::SYNC_STAGES-1:0] di_sync;

	// previous synced sck for edge detect
	logic sck_d;

	logic       sck_s;
	logic       ss_n_s;
	logic       di_s;
	logic       sck_rise;
	logic [2:0] bit_cnt;
	logic [6:0] shreg;

	// synced versions of the pins
	assign sck_s  = sck_sync[ldr_pkg::SYNC_STAGES-1];
	assign ss_n_s = ss_sync[ldr_pkg::SYNC_STAGES-1];
	assign di_s   = di_sync[ldr_pkg::SYNC_STAGES-1];

	// data and clock share the same delay, so di_s is the bit sampled at the edge
	assign sck_rise = sck_s & ~sck_d;

	// select is active low on the pin
	assign active_o = ~ss_n_s;

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			sck_sync     <= '0;
			// idle select is high
			ss_sync      <= '1;
			di_sync      <= '0;
			sck_d        <= 1'b0;
			bit_cnt      <= 3'd0;
			byte_valid_o <= 1'b0;
		end else begin
			sck_sync     <= {sck_sync[ldr_pkg::SYNC_STAGES-2:0], spi_sck_i};
			ss_sync      <= {ss_sync[ldr_pkg::SYNC_STAGES-2:0], spi_ss_n_i};
			di_sync      <= {di_sync[ldr_pkg::SYNC_STAGES-2:0], spi_di_i};
			sck_d        <= sck_s;
			byte_valid_o <= 1'b0;
			// deselect drops any half received byte
			if (ss_n_s) begin
				bit_cnt <= 3'd0;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				// eighth bit completes the byte
				if (bit_cnt == 3'd7)
					byte_valid_o <= 1'b1;
			end
		end
	end

	// msb first shift, no reset on the data path
	always_ff @(posedge clk_32m) begin
		if (!ss_n_s && sck_rise) begin
			shreg <= {shreg[5:0], di_s};
			if (bit_cnt == 3'd7)
				byte_o <= {shreg, di_s};
		end
	end

endmodule

// ==== src/download_packer.sv ====
`timescale 1ns/10ps

module download_packer (
	input  logic       clk_32m,
	input  logic       rst_n_i,
	input  logic [7:0] byte_i,
	input  logic       byte_valid_i,
	input  logic       active_i,
	input  logic       wr_done_i,
	loader_if.source   ld,
	output logic       busy_o
);

	// lane for the next byte, lane 0 is the low byte
	logic [1:0] lane_q;

	// word being assembled
	logic [ldr_pkg::DATA_W-1:0] acc_data_q;
	logic [ldr_pkg::SEL_W-1:0]  acc_sel_q;
	logic [ldr_pkg::DATA_W-1:0] word_nxt;
	logic [ldr_pkg::SEL_W-1:0]  sel_nxt;

	// running byte address of the word in assembly
	logic [ldr_pkg::ADDR_W-1:0] addr_q;

	// request registers, stable between wr pulses
	logic [ldr_pkg::ADDR_W-1:0] ld_addr_q;
	logic [ldr_pkg::DATA_W-1:0] ld_data_q;
	logic [ldr_pkg::SEL_W-1:0]  ld_sel_q;
	logic                       wr_q;

	logic active_d;
	logic pending_q;
	logic act_rise;
	logic act_fall;
	logic emit;

	assign act_rise = active_i & ~active_d;
	assign act_fall = ~active_i & active_d;

	// word and selects including the byte arriving this cycle
	always_comb begin
		word_nxt = acc_data_q;
		sel_nxt  = acc_sel_q;
		if (byte_valid_i) begin
			word_nxt[{lane_q, 3'b000} +: 8] = byte_i;
			sel_nxt[lane_q]                 = 1'b1;
		end
	end

	// full word, or a partial one left over when select goes high
	assign emit = (byte_valid_i && lane_q == 2'd3) || (act_fall && sel_nxt != '0);

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			active_d  <= 1'b0;
			lane_q    <= 2'd0;
			acc_sel_q <= '0;
			addr_q    <= ldr_pkg::LOAD_BASE;
			wr_q      <= 1'b0;
			pending_q <= 1'b0;
		end else begin
			active_d <= active_i;
			// wr follows the fourth byte or the fall by one cycle
			wr_q     <= emit;
			if (act_rise) begin
				// every download starts over at the load base
				addr_q    <= ldr_pkg::LOAD_BASE;
				lane_q    <= 2'd0;
				acc_sel_q <= '0;
			end else if (emit) begin
				addr_q    <= addr_q + ldr_pkg::ADDR_W'(4);
				lane_q    <= 2'd0;
				acc_sel_q <= '0;
			end else if (act_fall) begin
				lane_q    <= 2'd0;
				acc_sel_q <= '0;
			end else if (byte_valid_i) begin
				lane_q    <= lane_q + 2'd1;
				acc_sel_q <= sel_nxt;
			end
			// outstanding write until the bus acks it
			if (emit)
				pending_q <= 1'b1;
			else if (wr_done_i)
				pending_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_32m) begin
		if (byte_valid_i)
			acc_data_q <= word_nxt;
		if (emit) begin
			ld_data_q <= word_nxt;
			ld_sel_q  <= sel_nxt;
			ld_addr_q <= addr_q;
		end
	end

	assign ld.wr   = wr_q;
	assign ld.addr = ld_addr_q;
	assign ld.sel  = ld_sel_q;
	assign ld.data = ld_data_q;

	// active_d bridges the cycle between the fall and a flush pulse
	assign busy_o = active_i | active_d | pending_q;

endmodule

// ==== src/mem_bus_mux.sv ====
`timescale 1ns/10ps

module mem_bus_mux (
	input  logic        clk_32m,
	input  logic        rst_n_i,
	input  logic        loading_i,
	loader_if.sink      ld,
	wb_if.master        wb,
	output logic        wr_done_o,
	input  logic        core_cyc_i,
	input  logic        core_stb_i,
	input  logic        core_we_i,
	input  logic [3:0]  core_sel_i,
	input  logic [23:0] core_adr_i,
	input  logic [31:0] core_dat_i,
	output logic [31:0] core_dat_o,
	output logic        core_ack_o
);

	// loader strobe, held from the wr pulse until ram ack
	logic loader_stb;

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			loader_stb <= 1'b0;
		end else if (ld.wr) begin
			loader_stb <= 1'b1;
		end else if (wb.ack) begin
			// drops the cycle after ack
			loader_stb <= 1'b0;
		end
	end

	// ack of a loader cycle frees the packer for the next word
	assign wr_done_o = loader_stb & wb.ack;

	// loader owns the bus for the whole download
	assign wb.cyc = loading_i ? loader_stb : core_cyc_i;
	assign wb.stb = loading_i ? loader_stb : core_stb_i;
	// loader only ever writes
	assign wb.we  = loading_i ? 1'b1 : core_we_i;
	assign wb.sel = loading_i ? ld.sel : core_sel_i;

	// word aligned on both paths
	assign wb.adr = loading_i ? {ld.addr[23:2], 2'b00} : {core_adr_i[23:2], 2'b00};

	assign wb.dat_w = loading_i ? ld.data : core_dat_i;

	// read data goes straight back to the core
	assign core_dat_o = wb.dat_r;

	// core sees no ack while it is locked out
	assign core_ack_o = loading_i ? 1'b0 : wb.ack;

endmodule

// ==== src/wb_sram.sv ====
`timescale 1ns/10ps

module wb_sram (
	input  logic clk_32m,
	input  logic rst_n_i,
	wb_if.slave  wb
);

	// word storage, no reset on the array
	logic [ldr_pkg::DATA_W-1:0] mem [0:(1 << ldr_pkg::MEM_AW)-1];

	// word index, upper address bits ignored so accesses wrap
	logic [ldr_pkg::MEM_AW-1:0] idx;

	// new request seen this cycle
	logic req;

	logic ack_q;

	assign idx = wb.adr[ldr_pkg::MEM_AW+1:2];

	// a held strobe is not taken twice
	assign req = wb.cyc & wb.stb & ~ack_q;

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req;
	end

	// write lands on the ack edge, read data arrives with ack
	always_ff @(posedge clk_32m) begin
		if (req) begin
			if (wb.we) begin
				for (int i = 0; i < ldr_pkg::SEL_W; i++) begin
					// byte lanes gated by sel
					if (wb.sel[i])
						mem[idx][i*8 +: 8] <= wb.dat_w[i*8 +: 8];
				end
			end
			wb.dat_r <= mem[idx];
		end
	end

	assign wb.ack = ack_q;

endmodule

// ==== src/loader_mem_top.sv ====
`timescale 1ns/10ps

module loader_mem_top (
	input  logic        clk_32m,
	input  logic        rst_n_i,
	input  logic        spi_sck_i,
	input  logic        spi_ss_n_i,
	input  logic        spi_di_i,
	input  logic        core_cyc_i,
	input  logic        core_stb_i,
	input  logic        core_we_i,
	input  logic [3:0]  core_sel_i,
	input  logic [23:0] core_adr_i,
	input  logic [31:0] core_dat_i,
	output logic [31:0] core_dat_o,
	output logic        core_ack_o,
	output logic        core_reset_o
);

	// received byte stream
	logic [7:0] rx_byte;
	logic       rx_byte_valid;
	logic       rx_active;

	// download in progress or write still in flight
	logic busy;

	// loader word acknowledged by the ram
	logic wr_done;

	wb_if     ram_bus ();
	loader_if ld_bus ();

	// serial bytes from the host
	spi_byte_rx u_spi_byte_rx (
		.clk_32m      (clk_32m),
		.rst_n_i      (rst_n_i),
		.spi_sck_i    (spi_sck_i),
		.spi_ss_n_i   (spi_ss_n_i),
		.spi_di_i     (spi_di_i),
		.byte_o       (rx_byte),
		.byte_valid_o (rx_byte_valid),
		.active_o     (rx_active)
	);

	// bytes to words at consecutive addresses
	download_packer u_download_packer (
		.clk_32m      (clk_32m),
		.rst_n_i      (rst_n_i),
		.byte_i       (rx_byte),
		.byte_valid_i (rx_byte_valid),
		.active_i     (rx_active),
		.wr_done_i    (wr_done),
		.ld           (ld_bus.source),
		.busy_o       (busy)
	);

	// loader and core share the ram port
	mem_bus_mux u_mem_bus_mux (
		.clk_32m    (clk_32m),
		.rst_n_i    (rst_n_i),
		.loading_i  (busy),
		.ld         (ld_bus.sink),
		.wb         (ram_bus.master),
		.wr_done_o  (wr_done),
		.core_cyc_i (core_cyc_i),
		.core_stb_i (core_stb_i),
		.core_we_i  (core_we_i),
		.core_sel_i (core_sel_i),
		.core_adr_i (core_adr_i),
		.core_dat_i (core_dat_i),
		.core_dat_o (core_dat_o),
		.core_ack_o (core_ack_o)
	);

	// block ram in place of the sdram controller
	wb_sram u_wb_sram (
		.clk_32m (clk_32m),
		.rst_n_i (rst_n_i),
		.wb      (ram_bus.slave)
	);

	// core held in reset while the loader owns memory
	assign core_reset_o = busy;

endmodule

// ==== testbench/loader_mem_asserts.sv ====
`timescale 1ns/10ps

module mem_bus_mux_asserts (
	input logic clk_32m,
	input logic rst_n_i,
	input logic loading_i,
	input logic wr_i,
	input logic loader_stb_i,
	input logic stb_i,
	input logic ack_i
);

	// number of assertion failures so far
	int fail_cnt = 0;

	// ram acks only a live strobe
	ack_needs_stb: assert property (@(posedge clk_32m) disable iff (!rst_n_i) ack_i |-> stb_i)
		else begin
			$error("ram ack seen without a strobe");
			fail_cnt++;
		end

	// bus strobe held until acked, whoever owns the bus
	stb_until_ack: assert property (@(posedge clk_32m) disable iff (!rst_n_i)
		stb_i && !ack_i |=> stb_i)
		else begin
			$error("bus strobe dropped before ack");
			fail_cnt++;
		end

	// next word never overtakes the last one
	no_wr_pending: assert property (@(posedge clk_32m) disable iff (!rst_n_i)
		wr_i |-> !loader_stb_i)
		else begin
			$error("loader write pulse while a write is still pending");
			fail_cnt++;
		end

	// core locked out during a download, ram answers only the loader
	ram_serves_loader: assert property (@(posedge clk_32m) disable iff (!rst_n_i)
		loading_i && ack_i |-> loader_stb_i)
		else begin
			$error("ram acked a core cycle while the loader owns the bus");
			fail_cnt++;
		end

endmodule

// attached to every bus mux
bind mem_bus_mux mem_bus_mux_asserts u_asserts (
	.clk_32m      (clk_32m),
	.rst_n_i      (rst_n_i),
	.loading_i    (loading_i),
	.wr_i         (ld.wr),
	.loader_stb_i (loader_stb),
	.stb_i        (wb.stb),
	.ack_i        (wb.ack)
);

// ==== testbench/tb_loader_mem.sv ====
`timescale 1ns/10ps

module tb_loader_mem;

	localparam logic [31:0] SEED = 32'h2c8ddc71;
	// clk cycles per sck half period
	localparam int SCK_HALF = 10;
	// largest byte count of every download added up
	localparam int SPI_BYTES = 64 + 19 + 24 + 48;
	localparam int CORE_ACCESSES = 100;
	// 20 cycles per spi bit, 10 per core access, doubled
	localparam int MAX_CYCLES = 2 * (SPI_BYTES * 8 * 20 + CORE_ACCESSES * 10);

	logic        clk_32m;
	logic        rst_n_i;
	logic        spi_sck_i;
	logic        spi_ss_n_i;
	logic        spi_di_i;
	logic        core_cyc_i;
	logic        core_stb_i;
	logic        core_we_i;
	logic [3:0]  core_sel_i;
	logic [23:0] core_adr_i;
	logic [31:0] core_dat_i;
	logic [31:0] core_dat_o;
	logic        core_ack_o;
	logic        core_reset_o;

	// expected ram contents
	logic [ldr_pkg::DATA_W-1:0] model_mem [0:(1 << ldr_pkg::MEM_AW)-1];
	// payload of the next download
	logic [7:0] dl_bytes [$];

	int errors;
	int tests;
	int seed_val;
	int cycle_cnt;

	loader_mem_top UUT (
		.clk_32m      (clk_32m),
		.rst_n_i      (rst_n_i),
		.spi_sck_i    (spi_sck_i),
		.spi_ss_n_i   (spi_ss_n_i),
		.spi_di_i     (spi_di_i),
		.core_cyc_i   (core_cyc_i),
		.core_stb_i   (core_stb_i),
		.core_we_i    (core_we_i),
		.core_sel_i   (core_sel_i),
		.core_adr_i   (core_adr_i),
		.core_dat_i   (core_dat_i),
		.core_dat_o   (core_dat_o),
		.core_ack_o   (core_ack_o),
		.core_reset_o (core_reset_o)
	);

	initial begin
		clk_32m = 1'b0;
		forever #5 clk_32m = ~clk_32m;
	end

	// watchdog
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk_32m);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	// n edges, then 1 ns past the last one
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_32m);
		#1;
	endtask

	task automatic check_word(input string name, input logic [ldr_pkg::DATA_W-1:0] exp,
			input logic [ldr_pkg::DATA_W-1:0] act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	// byte lane write, word index from bits 11..2 so the model wraps too
	function automatic void model_write(input logic [ldr_pkg::ADDR_W-1:0] adr,
			input logic [ldr_pkg::SEL_W-1:0] sel, input logic [ldr_pkg::DATA_W-1:0] dat);
		for (int i = 0; i < ldr_pkg::SEL_W; i++)
			if (sel[i])
				model_mem[adr[ldr_pkg::MEM_AW+1:2]][i*8 +: 8] = dat[i*8 +: 8];
	endfunction

	// one classic cycle, stb kept through the ack cycle
	task automatic core_access(input string name, input logic we, input logic [3:0] sel,
			input logic [23:0] adr, input logic [31:0] dat, output logic [31:0] rdat);
		core_cyc_i = 1'b1;
		core_stb_i = 1'b1;
		core_we_i  = we;
		core_sel_i = sel;
		core_adr_i = adr;
		core_dat_i = dat;
		wait_cycles(1);
		while (!core_ack_o)
			wait_cycles(1);
		// ack only once the core is out of reset
		check_bit({name, " reset at ack"}, 1'b0, core_reset_o);
		rdat = core_dat_o;
		if (we)
			model_write(adr, sel, dat);
		wait_cycles(1);
		core_cyc_i = 1'b0;
		core_stb_i = 1'b0;
		core_we_i  = 1'b0;
		wait_cycles(1);
	endtask

	task automatic read_check(input string name, input logic [23:0] adr);
		logic [31:0] rdat;
		core_access(name, 1'b0, 4'hF, adr, '0, rdat);
		check_word(name, model_mem[adr[ldr_pkg::MEM_AW+1:2]], rdat);
	endtask

	task automatic fill_bytes(input int n);
		dl_bytes.delete();
		repeat (n)
			dl_bytes.push_back(8'($urandom));
	endtask

	// sck idles low, data set up half a period before each rising edge
	task automatic spi_download(input string name);
		spi_ss_n_i = 1'b0;
		foreach (dl_bytes[k]) begin
			for (int b = 7; b >= 0; b--) begin
				spi_di_i = dl_bytes[k][b];
				wait_cycles(SCK_HALF);
				spi_sck_i = 1'b1;
				wait_cycles(SCK_HALF);
				spi_sck_i = 1'b0;
			end
			// little endian, byte k in lane k mod 4
			model_write(ldr_pkg::LOAD_BASE + 24'(4 * (k / 4)), 4'(1 << (k % 4)),
				{4{dl_bytes[k]}});
		end
		wait_cycles(SCK_HALF);
		check_bit({name, " reset during download"}, 1'b1, core_reset_o);
		spi_ss_n_i = 1'b1;
		// done once the core leaves reset
		while (core_reset_o)
			wait_cycles(1);
	endtask

	task automatic verify_words(input string name, input int nbytes);
		for (int w = 0; w < (nbytes + 3) / 4; w++)
			read_check(name, ldr_pkg::LOAD_BASE + 24'(4 * w));
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		$display("test %-14s %s", name, (errors == errs_before) ? "passed" : "failed");
	endtask

	initial begin
		int errs_before;
		int n;
		logic [23:0] adr;
		logic [23:0] low_adr;
		logic [31:0] dat;
		logic [31:0] rdat;
		logic [ldr_pkg::MEM_AW-1:0] idx;

		seed_val = $urandom(SEED);
		errors = 0;
		tests = 0;
		rst_n_i = 1'b0;
		spi_sck_i = 1'b0;
		spi_ss_n_i = 1'b1;
		spi_di_i = 1'b0;
		core_cyc_i = 1'b0;
		core_stb_i = 1'b0;
		core_we_i = 1'b0;
		core_sel_i = '0;
		core_adr_i = '0;
		core_dat_i = '0;
		wait_cycles(10);
		rst_n_i = 1'b1;

		// idle outputs, then lane writes at random addresses
		errs_before = errors;
		check_bit("reset core_reset_o", 1'b0, core_reset_o);
		check_bit("reset core_ack_o", 1'b0, core_ack_o);
		repeat (8) begin
			adr = 24'($urandom);
			core_access("core full write", 1'b1, 4'hF, adr, $urandom, rdat);
			core_access("core lane write", 1'b1, 4'($urandom), adr, $urandom, rdat);
			read_check("core readback", adr);
		end
		end_test("after reset", errs_before);

		errs_before = errors;
		n = 4 * $urandom_range(1, 16);
		fill_bytes(n);
		spi_download("full words");
		verify_words("full words", n);
		end_test("full words", errs_before);

		// lanes past the last byte keep the preload
		errs_before = errors;
		n = 4 * $urandom_range(0, 4) + $urandom_range(1, 3);
		for (int w = 0; w <= n / 4; w++)
			core_access("preload", 1'b1, 4'hF, ldr_pkg::LOAD_BASE + 24'(4 * w), $urandom, rdat);
		fill_bytes(n);
		spi_download("partial word");
		verify_words("partial word", n);
		end_test("partial word", errs_before);

		// core write aimed at the last loaded word, must land after it
		errs_before = errors;
		fill_bytes(24);
		adr = ldr_pkg::LOAD_BASE + 24'd20;
		dat = $urandom;
		fork
			spi_download("lockout");
			begin
				while (!core_reset_o)
					wait_cycles(1);
				wait_cycles(50);
				core_access("lockout write", 1'b1, 4'hF, adr, dat, rdat);
			end
		join
		verify_words("lockout", 24);
		end_test("core lockout", errs_before);

		errs_before = errors;
		fill_bytes(32);
		spi_download("first download");
		fill_bytes(16);
		spi_download("second download");
		verify_words("repeated", 32);
		end_test("repeated", errs_before);

		// upper address bits nonzero, same ram word
		errs_before = errors;
		repeat (4) begin
			idx = ldr_pkg::MEM_AW'($urandom);
			low_adr = 24'(idx) << 2;
			adr = low_adr | (24'($urandom_range(1, 4095)) << (ldr_pkg::MEM_AW + 2));
			core_access("wrap high write", 1'b1, 4'hF, adr, $urandom, rdat);
			read_check("wrap low read", low_adr);
			core_access("wrap low write", 1'b1, 4'hF, low_adr, $urandom, rdat);
			read_check("wrap high read", adr);
		end
		end_test("address wrap", errs_before);

		errors += UUT.u_mem_bus_mux.u_asserts.fail_cnt;
		$display("%0d tests, %0d errors, %0d of them bus assertion failures", tests, errors,
			UUT.u_mem_bus_mux.u_asserts.fail_cnt);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
src/ldr_pkg.sv
src/wb_if.sv
src/loader_if.sv
src/spi_byte_rx.sv
src/download_packer.sv
src/mem_bus_mux.sv
src/wb_sram.sv
src/loader_mem_top.sv
testbench/loader_mem_asserts.sv
testbench/tb_loader_mem.sv

// ==== Bender.yml ====
package:
  name: loader_mem

sources:
  - src/ldr_pkg.sv
  - src/wb_if.sv
  - src/loader_if.sv
  - src/spi_byte_rx.sv
  - src/download_packer.sv
  - src/mem_bus_mux.sv
  - src/wb_sram.sv
  - src/loader_mem_top.sv
  - target: test
    files:
      - testbench/loader_mem_asserts.sv
      - testbench/tb_loader_mem.sv
